// ==== hw/muldiv_cfg_pkg.sv ====
package muldiv_cfg_pkg;

  // datapath width of the core
  localparam int unsigned XLEN = 64;

  // width of the issue tag
  localparam int unsigned TRANS_ID_BITS = 3;

  // cycles from the issue cycle to the multiplier result
  localparam int unsigned MUL_LATENCY = 2;

  // divider step counter covers XLEN steps and one result cycle
  localparam int unsigned DIV_CNT_BITS = $clog2(XLEN + 1);

  // one operand or one result
  typedef logic [XLEN-1:0] xlen_t;

  // tag handed back with each result
  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

endpackage

// ==== hw/muldiv_op_pkg.sv ====
package muldiv_op_pkg;
  import muldiv_cfg_pkg::*;

  // M extension operations handled by this unit
  typedef enum logic [3:0] {
    MUL, MULH, MULHU, MULHSU, MULW,
    DIV, DIVU, DIVW, DIVUW,
    REM, REMU, REMW, REMUW
  } fu_op_e;

  // one issued operation
  typedef struct packed {
    fu_op_e    operation;
    xlen_t     operand_a;
    xlen_t     operand_b;
    trans_id_t trans_id;
  } fu_data_t;

  // bit positions inside the 2-bit divider opcode
  localparam int unsigned DIV_OPC_SIGNED = 0;
  localparam int unsigned DIV_OPC_REM    = 1;

  // which part of the product goes to the result
  typedef logic [1:0] mul_sel_t;
  localparam mul_sel_t MUL_SEL_LOW  = 2'd0;
  localparam mul_sel_t MUL_SEL_HIGH = 2'd1;
  localparam mul_sel_t MUL_SEL_WORD = 2'd2;

  function automatic logic is_mul_op(fu_op_e op);
    return op inside {MUL, MULH, MULHU, MULHSU, MULW};
  endfunction

  function automatic logic is_div_op(fu_op_e op);
    return op inside {DIV, DIVU, DIVW, DIVUW, REM, REMU, REMW, REMUW};
  endfunction

  // 32-bit variants, result is sign extended from bit 31
  function automatic logic is_word_op(fu_op_e op);
    return op inside {MULW, DIVW, DIVUW, REMW, REMUW};
  endfunction

  function automatic logic is_signed_div(fu_op_e op);
    return op inside {DIV, DIVW, REM, REMW};
  endfunction

  function automatic logic is_rem(fu_op_e op);
    return op inside {REM, REMU, REMW, REMUW};
  endfunction

  function automatic xlen_t sext32to64(logic [31:0] val);
    return {{(XLEN - 32){val[31]}}, val};
  endfunction

endpackage

// ==== hw/multiplier.sv ====
module multiplier
  import muldiv_cfg_pkg::*;
  import muldiv_op_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      mult_valid_i,
  input  fu_op_e    operation_i,
  input  xlen_t     operand_a_i,
  input  xlen_t     operand_b_i,
  input  trans_id_t trans_id_i,
  output xlen_t     result_o,
  output logic      mult_valid_o,
  output trans_id_t mult_trans_id_o
);

  // operand signedness and result select for the incoming op
  logic     sign_a;
  logic     sign_b;
  mul_sel_t sel_d;

  // stage one
  logic                valid1_q;
  logic signed [XLEN:0] op_a_q;
  logic signed [XLEN:0] op_b_q;
  mul_sel_t            sel1_q;
  trans_id_t           id1_q;

  // stage two
  logic                     valid2_q;
  logic signed [2*XLEN+1:0] prod_d;
  logic signed [2*XLEN+1:0] prod_q;
  mul_sel_t                 sel2_q;
  trans_id_t                id2_q;

  // --------------------------------------------------------------------
  // operation decode
  // --------------------------------------------------------------------
  always_comb begin
    sign_a = 1'b0;
    sign_b = 1'b0;
    sel_d  = MUL_SEL_LOW;
    case (operation_i)
      MULH: begin
        sign_a = 1'b1;
        sign_b = 1'b1;
        sel_d  = MUL_SEL_HIGH;
      end
      MULHU: begin
        sel_d = MUL_SEL_HIGH;
      end
      MULHSU: begin
        // rs1 signed, rs2 unsigned
        sign_a = 1'b1;
        sel_d  = MUL_SEL_HIGH;
      end
      MULW: begin
        sel_d = MUL_SEL_WORD;
      end
      // MUL keeps the low word, signedness does not matter there
      default: ;
    endcase
  end

  // one extra bit lets a single signed multiply cover all three variants
  assign prod_d = op_a_q * op_b_q;

  // valid bits walk through both stages
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid1_q <= 1'b0;
      valid2_q <= 1'b0;
    end else begin
      valid1_q <= mult_valid_i;
      valid2_q <= valid1_q;
    end
  end

  // datapath registers, only loaded when their stage holds an op
  always_ff @(posedge clk_i) begin
    if (mult_valid_i) begin
      op_a_q <= {sign_a & operand_a_i[XLEN-1], operand_a_i};
      op_b_q <= {sign_b & operand_b_i[XLEN-1], operand_b_i};
      sel1_q <= sel_d;
      id1_q  <= trans_id_i;
    end
    if (valid1_q) begin
      prod_q <= prod_d;
      sel2_q <= sel1_q;
      id2_q  <= id1_q;
    end
  end

  // --------------------------------------------------------------------
  // result select
  // --------------------------------------------------------------------
  always_comb begin
    case (sel2_q)
      MUL_SEL_HIGH: result_o = prod_q[2*XLEN-1:XLEN];
      MUL_SEL_WORD: result_o = sext32to64(prod_q[31:0]);
      default:      result_o = prod_q[XLEN-1:0];
    endcase
  end

  assign mult_valid_o    = valid2_q;
  assign mult_trans_id_o = id2_q;

endmodule

// ==== hw/serdiv.sv ====
module serdiv
  import muldiv_cfg_pkg::*;
  import muldiv_op_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_i,
  input  logic       in_vld_i,
  input  xlen_t      op_a_i,
  input  xlen_t      op_b_i,
  input  logic [1:0] opcode_i,
  input  trans_id_t  id_i,
  input  logic       out_rdy_i,
  output logic       in_rdy_o,
  output logic       out_vld_o,
  output xlen_t      res_o,
  output trans_id_t  id_o
);

  typedef enum logic [1:0] {
    IDLE,
    DIVIDE,
    FINISH
  } div_state_e;

  div_state_e state_d, state_q;

  // control
  logic [DIV_CNT_BITS-1:0] cnt_d, cnt_q;
  logic rem_sel_d, rem_sel_q;
  logic neg_quo_d, neg_quo_q;
  logic neg_rem_d, neg_rem_q;

  // datapath
  xlen_t     divisor_d, divisor_q;
  xlen_t     rem_d, rem_q;
  xlen_t     quo_d, quo_q;
  xlen_t     res_d, res_q;
  trans_id_t id_d, id_q;

  // operand preparation
  logic  a_neg;
  logic  b_neg;
  xlen_t a_abs;
  xlen_t b_abs;

  // one shift-subtract step
  logic [XLEN:0] rem_shift;
  logic [XLEN:0] diff;
  logic          fits;

  // sign corrected results
  xlen_t quo_fix;
  xlen_t rem_fix;

  // --------------------------------------------------------------------
  // operand magnitudes
  // --------------------------------------------------------------------
  assign a_neg = opcode_i[DIV_OPC_SIGNED] & op_a_i[XLEN-1];
  assign b_neg = opcode_i[DIV_OPC_SIGNED] & op_b_i[XLEN-1];
  assign a_abs = a_neg ? -op_a_i : op_a_i;
  assign b_abs = b_neg ? -op_b_i : op_b_i;

  // --------------------------------------------------------------------
  // restoring division step
  // --------------------------------------------------------------------
  // next dividend bit shifts from the quotient register into the remainder
  assign rem_shift = {rem_q, quo_q[XLEN-1]};
  assign diff      = rem_shift - {1'b0, divisor_q};
  // no borrow means the divisor fits
  assign fits      = ~diff[XLEN];

  // quotient is negative when signs differ, remainder follows the dividend
  // most negative by -1 wraps back to itself here, as RISC-V expects
  assign quo_fix = neg_quo_q ? -quo_q : quo_q;
  assign rem_fix = neg_rem_q ? -rem_q : rem_q;

  // --------------------------------------------------------------------
  // state machine
  // --------------------------------------------------------------------
  always_comb begin
    state_d   = state_q;
    cnt_d     = cnt_q;
    rem_sel_d = rem_sel_q;
    neg_quo_d = neg_quo_q;
    neg_rem_d = neg_rem_q;
    divisor_d = divisor_q;
    rem_d     = rem_q;
    quo_d     = quo_q;
    res_d     = res_q;
    id_d      = id_q;

    case (state_q)
      IDLE: begin
        if (in_vld_i) begin
          id_d      = id_i;
          rem_sel_d = opcode_i[DIV_OPC_REM];
          neg_quo_d = a_neg ^ b_neg;
          neg_rem_d = a_neg;
          if (op_b_i == '0) begin
            // divide by zero skips the loop
            // quotient all ones, remainder is the dividend
            res_d   = opcode_i[DIV_OPC_REM] ? op_a_i : '1;
            state_d = FINISH;
          end else begin
            divisor_d = b_abs;
            rem_d     = '0;
            quo_d     = a_abs;
            cnt_d     = '0;
            state_d   = DIVIDE;
          end
        end
      end
      DIVIDE: begin
        if (cnt_q == DIV_CNT_BITS'(XLEN)) begin
          // all bits done, register the corrected result
          res_d   = rem_sel_q ? rem_fix : quo_fix;
          state_d = FINISH;
        end else begin
          rem_d = fits ? diff[XLEN-1:0] : rem_shift[XLEN-1:0];
          quo_d = {quo_q[XLEN-2:0], fits};
          cnt_d = cnt_q + 1'b1;
        end
      end
      FINISH: begin
        // hold the result until the output is free
        if (out_rdy_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase

    // flush drops whatever is running and blocks acceptance
    if (flush_i) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      cnt_q     <= '0;
      rem_sel_q <= 1'b0;
      neg_quo_q <= 1'b0;
      neg_rem_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      cnt_q     <= cnt_d;
      rem_sel_q <= rem_sel_d;
      neg_quo_q <= neg_quo_d;
      neg_rem_q <= neg_rem_d;
    end
  end

  always_ff @(posedge clk_i) begin
    divisor_q <= divisor_d;
    rem_q     <= rem_d;
    quo_q     <= quo_d;
    res_q     <= res_d;
    id_q      <= id_d;
  end

  assign in_rdy_o  = (state_q == IDLE);
  assign out_vld_o = (state_q == FINISH);
  assign res_o     = res_q;
  assign id_o      = id_q;

endmodule

// ==== hw/mult_unit.sv ====
module mult_unit
  import muldiv_cfg_pkg::*;
  import muldiv_op_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,
  input  fu_data_t  fu_data_i,
  input  logic      mult_valid_i,
  output xlen_t     result_o,
  output logic      mult_valid_o,
  output logic      mult_ready_o,
  output trans_id_t mult_trans_id_o
);

  // issue strobes per class
  logic mul_valid_op;
  logic div_valid_op;

  // multiplier side
  logic      mul_valid;
  xlen_t     mul_result;
  trans_id_t mul_trans_id;

  // divider side
  xlen_t      div_op_a;
  xlen_t      div_op_b;
  logic [1:0] div_opcode;
  logic       div_valid;
  logic       div_ready;
  xlen_t      div_raw;
  xlen_t      div_result;
  trans_id_t  div_trans_id;

  // set while the divider works on a word op
  logic word_op_q;

  // --------------------------------------------------------------------
  // input decode
  // --------------------------------------------------------------------
  // nothing new is accepted in a flush cycle
  assign mul_valid_op = mult_valid_i & ~flush_i & is_mul_op(fu_data_i.operation);
  assign div_valid_op = mult_valid_i & ~flush_i & is_div_op(fu_data_i.operation);

  // --------------------------------------------------------------------
  // multiplier
  // --------------------------------------------------------------------
  multiplier i_multiplier (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .mult_valid_i   (mul_valid_op),
    .operation_i    (fu_data_i.operation),
    .operand_a_i    (fu_data_i.operand_a),
    .operand_b_i    (fu_data_i.operand_b),
    .trans_id_i     (fu_data_i.trans_id),
    .result_o       (mul_result),
    .mult_valid_o   (mul_valid),
    .mult_trans_id_o(mul_trans_id)
  );

  // --------------------------------------------------------------------
  // divider front end
  // --------------------------------------------------------------------
  always_comb begin
    // divider inputs stay quiet for non-divide ops
    div_op_a = '0;
    div_op_b = '0;
    if (is_div_op(fu_data_i.operation)) begin
      if (is_word_op(fu_data_i.operation)) begin
        // word ops only see the low 32 bits
        if (is_signed_div(fu_data_i.operation)) begin
          div_op_a = sext32to64(fu_data_i.operand_a[31:0]);
          div_op_b = sext32to64(fu_data_i.operand_b[31:0]);
        end else begin
          div_op_a = {{(XLEN - 32){1'b0}}, fu_data_i.operand_a[31:0]};
          div_op_b = {{(XLEN - 32){1'b0}}, fu_data_i.operand_b[31:0]};
        end
      end else begin
        div_op_a = fu_data_i.operand_a;
        div_op_b = fu_data_i.operand_b;
      end
    end
  end

  assign div_opcode[DIV_OPC_REM]    = is_rem(fu_data_i.operation);
  assign div_opcode[DIV_OPC_SIGNED] = is_signed_div(fu_data_i.operation);

  // remember the word flag of the op the divider just took
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_op_q <= 1'b0;
    end else if (div_valid_op && mult_ready_o) begin
      word_op_q <= is_word_op(fu_data_i.operation);
    end
  end

  serdiv i_div (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .flush_i  (flush_i),
    .in_vld_i (div_valid_op),
    .op_a_i   (div_op_a),
    .op_b_i   (div_op_b),
    .opcode_i (div_opcode),
    .id_i     (fu_data_i.trans_id),
    .out_rdy_i(div_ready),
    .in_rdy_o (mult_ready_o),
    .out_vld_o(div_valid),
    .res_o    (div_raw),
    .id_o     (div_trans_id)
  );

  // word results are sign extended from bit 31
  assign div_result = word_op_q ? sext32to64(div_raw[31:0]) : div_raw;

  // --------------------------------------------------------------------
  // output arbitration
  // --------------------------------------------------------------------
  // multiplier cannot stall, so it wins and the divider holds its result
  assign div_ready       = ~mul_valid;
  assign mult_valid_o    = mul_valid | div_valid;
  assign result_o        = mul_valid ? mul_result : div_result;
  assign mult_trans_id_o = mul_valid ? mul_trans_id : div_trans_id;

endmodule

// ==== dv/tb_clk_gen.sv ====
module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int unsigned HALF_PERIOD  = 2;
  localparam int unsigned RESET_CYCLES = 2;

  // free running clock, period 4
  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // reset released just after an edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

// ==== dv/tb_mult_checker.sv ====
module tb_mult_checker
  import muldiv_cfg_pkg::*;
  import muldiv_op_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,
  input  fu_data_t  fu_data_i,
  input  logic      mult_valid_i,
  input  xlen_t     result_i,
  input  logic      out_valid_i,
  input  logic      ready_i,
  input  trans_id_t out_trans_id_i,
  input  int        test_num_i,
  input  logic      test_end_i,
  output logic      idle_o,
  output int        pass_cnt_o,
  output int        fail_cnt_o
);

  localparam int unsigned NUM_TAGS = 2 ** TRANS_ID_BITS;

  // scoreboard, one slot per tag
  logic [NUM_TAGS-1:0] pending;
  xlen_t               exp_res  [NUM_TAGS];
  int                  issue_cyc[NUM_TAGS];
  logic                is_mul_q [NUM_TAGS];

  logic flush_q  = 1'b0;
  int   cyc      = 0;
  int   test_err = 0;
  int   pass_cnt = 0;
  int   fail_cnt = 0;

  assign idle_o     = (pending == '0);
  assign pass_cnt_o = pass_cnt;
  assign fail_cnt_o = fail_cnt;

  // ------------------------------------------------------------------
  // reference model of the M extension
  // ------------------------------------------------------------------
  function automatic xlen_t mul_div_ref(fu_op_e op, xlen_t a, xlen_t b);
    logic [2*XLEN-1:0]      prod;
    logic [31:0]            word;
    logic signed [XLEN-1:0] sx;
    logic signed [XLEN-1:0] sy;
    xlen_t                  x;
    xlen_t                  y;
    xlen_t                  q;
    xlen_t                  r;
    xlen_t                  res;
    case (op)
      MUL:    res = a * b;
      MULH: begin
        prod = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{b[XLEN-1]}}, b};
        res  = prod[2*XLEN-1:XLEN];
      end
      MULHU: begin
        prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        res  = prod[2*XLEN-1:XLEN];
      end
      MULHSU: begin
        prod = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{1'b0}}, b};
        res  = prod[2*XLEN-1:XLEN];
      end
      MULW: begin
        word = a[31:0] * b[31:0];
        res  = {{(XLEN - 32){word[31]}}, word};
      end
      default: begin
        // word ops see only the low halves
        x = a;
        y = b;
        if (is_word_op(op) && is_signed_div(op)) begin
          x = {{(XLEN - 32){a[31]}}, a[31:0]};
          y = {{(XLEN - 32){b[31]}}, b[31:0]};
        end else if (is_word_op(op)) begin
          x = {{(XLEN - 32){1'b0}}, a[31:0]};
          y = {{(XLEN - 32){1'b0}}, b[31:0]};
        end
        if (y == '0) begin
          q = '1;
          r = x;
        end else if (is_signed_div(op) && x == {1'b1, {(XLEN - 1){1'b0}}} && y == '1) begin
          // signed overflow
          q = x;
          r = '0;
        end else if (is_signed_div(op)) begin
          sx = x;
          sy = y;
          q  = sx / sy;
          r  = sx % sy;
        end else begin
          q = x / y;
          r = x % y;
        end
        res = is_rem(op) ? r : q;
        if (is_word_op(op)) res = {{(XLEN - 32){res[31]}}, res[31:0]};
      end
    endcase
    return res;
  endfunction

  always @(posedge clk_i) cyc <= cyc + 1;

  // ------------------------------------------------------------------
  // compare process, samples mid cycle
  // ------------------------------------------------------------------
  always @(negedge clk_i) begin
    trans_id_t t;
    if (!rst_ni) begin
      pending = '0;
      flush_q = 1'b0;
    end else begin
      // results leaving the unit
      if (out_valid_i === 1'b1) begin
        t = out_trans_id_i;
        if (!pending[t]) begin
          $display("test %0d: unexpected or duplicate result for tag %0d", test_num_i, t);
          test_err++;
        end else begin
          if (result_i !== exp_res[t]) begin
            $display("ERROR result_o tag %0d: expected %h actual %h", t, exp_res[t], result_i);
            test_err++;
          end
          if (is_mul_q[t] && (cyc - issue_cyc[t]) != MUL_LATENCY) begin
            $display("test %0d: multiply tag %0d came after %0d cycles instead of %0d",
                     test_num_i, t, cyc - issue_cyc[t], MUL_LATENCY);
            test_err++;
          end
          pending[t] = 1'b0;
        end
      end else if (out_valid_i !== 1'b0) begin
        $display("ERROR mult_valid_o: expected %h actual %h", 1'b0, out_valid_i);
        test_err++;
      end
      // divider must be free in idle and right after a flush
      if ((flush_q || test_num_i == 1) && ready_i !== 1'b1) begin
        $display("ERROR mult_ready_o: expected %h actual %h", 1'b1, ready_i);
        test_err++;
      end
      // flush kills the divide, multiplies carry on
      if (flush_i) begin
        for (int i = 0; i < NUM_TAGS; i++) begin
          if (pending[i] && !is_mul_q[i]) pending[i] = 1'b0;
        end
      end
      flush_q = flush_i;
      // record what the unit takes at the next edge
      if (mult_valid_i && !flush_i && (is_mul_op(fu_data_i.operation) ||
          (is_div_op(fu_data_i.operation) && ready_i === 1'b1))) begin
        t = fu_data_i.trans_id;
        if (pending[t]) begin
          $display("test %0d: tag %0d issued again while in flight", test_num_i, t);
          test_err++;
        end
        pending[t]   = 1'b1;
        is_mul_q[t]  = is_mul_op(fu_data_i.operation);
        issue_cyc[t] = cyc;
        exp_res[t]   = mul_div_ref(fu_data_i.operation, fu_data_i.operand_a,
                                   fu_data_i.operand_b);
      end
      // one summary line per test
      if (test_end_i) begin
        for (int i = 0; i < NUM_TAGS; i++) begin
          if (pending[i]) begin
            $display("test %0d: result for tag %0d never arrived", test_num_i, i);
            test_err++;
          end
        end
        pending = '0;
        if (test_err == 0) begin
          $display("test %0d passed", test_num_i);
          pass_cnt++;
        end else begin
          $display("test %0d failed with %0d errors", test_num_i, test_err);
          fail_cnt++;
        end
        test_err = 0;
      end
    end
  end

endmodule

// ==== dv/tb_mult_unit.sv ====
module tb_mult_unit
  import muldiv_cfg_pkg::*;
  import muldiv_op_pkg::*;
();

  localparam logic [31:0] SEED = 32'h845e_a880;
  localparam int unsigned NUM_TAGS = 2 ** TRANS_ID_BITS;

  // operation counts per test
  localparam int unsigned N_MUL        = 40;
  localparam int unsigned N_DIV_CASES  = 5;
  localparam int unsigned N_DIV        = 8 * N_DIV_CASES;
  localparam int unsigned N_CONT_ROUND = 2;
  localparam int unsigned N_CONT_MULS  = 16;
  localparam int unsigned N_FLUSH      = 5;
  localparam int unsigned N_MIX        = 60;
  localparam int unsigned N_OPS = N_MUL + N_DIV + N_CONT_ROUND * (N_CONT_MULS + 1) +
                                  N_FLUSH + N_MIX;
  localparam int unsigned TIMEOUT_CYCLES = N_OPS * (XLEN + 8) + 200;

  // longest divide plus output hold, with margin
  localparam int unsigned DRAIN_CYCLES = 2 * (XLEN + 8);

  logic      clk_i;
  logic      rst_ni;
  logic      flush_i;
  fu_data_t  fu_data_i;
  logic      mult_valid_i;
  xlen_t     result_o;
  logic      mult_valid_o;
  logic      mult_ready_o;
  trans_id_t mult_trans_id_o;

  int        test_num;
  logic      test_end;
  logic      idle;
  int        pass_cnt;
  int        fail_cnt;
  int        cycle_cnt = 0;
  trans_id_t tag_ptr   = '0;

  fu_op_e mul_ops[5] = '{MUL, MULH, MULHU, MULHSU, MULW};
  fu_op_e div_ops[8] = '{DIV, DIVU, REM, REMU, DIVW, DIVUW, REMW, REMUW};
  xlen_t  corners[8] = '{64'h0, 64'h1, '1, 64'h8000_0000_0000_0000,
                         64'h7fff_ffff_ffff_ffff, 64'h0000_0000_ffff_ffff,
                         64'h0000_0000_8000_0000, 64'hffff_ffff_7fff_ffff};

  tb_clk_gen i_clk_gen (
    .clk_o (clk_i),
    .rst_no(rst_ni)
  );

  mult_unit i_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .fu_data_i      (fu_data_i),
    .mult_valid_i   (mult_valid_i),
    .result_o       (result_o),
    .mult_valid_o   (mult_valid_o),
    .mult_ready_o   (mult_ready_o),
    .mult_trans_id_o(mult_trans_id_o)
  );

  tb_mult_checker i_checker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .fu_data_i     (fu_data_i),
    .mult_valid_i  (mult_valid_i),
    .result_i      (result_o),
    .out_valid_i   (mult_valid_o),
    .ready_i       (mult_ready_o),
    .out_trans_id_i(mult_trans_id_o),
    .test_num_i    (test_num),
    .test_end_i    (test_end),
    .idle_o        (idle),
    .pass_cnt_o    (pass_cnt),
    .fail_cnt_o    (fail_cnt)
  );

  // ------------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------------
  // inputs change 1 unit after the rising edge
  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  // mostly random, sometimes a corner value
  function automatic xlen_t rand_operand();
    if ($urandom_range(3) == 0) return corners[$urandom_range(7)];
    return {$urandom, $urandom};
  endfunction

  // rotate through tags, skipping ones still in flight
  task automatic next_tag(output trans_id_t t);
    int tries;
    tries = 0;
    while (i_checker.pending[tag_ptr] && tries < NUM_TAGS) begin
      tag_ptr++;
      tries++;
    end
    t = tag_ptr;
    tag_ptr++;
  endtask

  task automatic issue(input fu_op_e op, input xlen_t a, input xlen_t b);
    trans_id_t t;
    next_tag(t);
    fu_data_i.operation = op;
    fu_data_i.operand_a = a;
    fu_data_i.operand_b = b;
    fu_data_i.trans_id  = t;
    mult_valid_i = 1'b1;
    step();
    mult_valid_i = 1'b0;
  endtask

  // divides only go out while the divider is free
  task automatic issue_div(input fu_op_e op, input xlen_t a, input xlen_t b);
    while (mult_ready_o !== 1'b1) step();
    issue(op, a, b);
  endtask

  // let the results drain for a bounded time, then close the test
  task automatic finish_test();
    int waited;
    waited = 0;
    while (!idle && waited < DRAIN_CYCLES) begin
      step();
      waited++;
    end
    repeat (4) step();
    test_end = 1'b1;
    step();
    test_end = 1'b0;
  endtask

  // ------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------
  initial begin
    fu_op_e op;
    flush_i      = 1'b0;
    mult_valid_i = 1'b0;
    fu_data_i    = '0;
    test_num     = 0;
    test_end     = 1'b0;
    void'($urandom(SEED));
    wait (rst_ni === 1'b1);
    step();

    // idle after reset
    test_num = 1;
    repeat (4) step();
    finish_test();

    // back to back multiplies
    test_num = 2;
    for (int i = 0; i < N_MUL; i++) begin
      issue(mul_ops[$urandom_range(4)], rand_operand(), rand_operand());
    end
    finish_test();

    // divide corner cases per op
    test_num = 3;
    for (int i = 0; i < 8; i++) begin
      op = div_ops[i];
      issue_div(op, rand_operand(), '0);
      issue_div(op, 64'h8000_0000_0000_0000, '1);
      issue_div(op, 64'hdead_beef_8000_0000, 64'h1234_5678_ffff_ffff);
      repeat (N_DIV_CASES - 3) issue_div(op, rand_operand(), rand_operand());
    end
    finish_test();

    // multiply stream across the divide finish
    test_num = 4;
    for (int r = 0; r < N_CONT_ROUND; r++) begin
      issue_div((r == 0) ? DIVU : REM, {$urandom, $urandom}, {$urandom, $urandom} | 64'h1);
      repeat (XLEN - 6) step();
      repeat (N_CONT_MULS) issue(mul_ops[$urandom_range(4)], rand_operand(), rand_operand());
    end
    finish_test();

    // flush kills a running divide and the op issued with it
    test_num = 5;
    issue_div(DIV, rand_operand(), 64'd7);
    repeat (10) step();
    issue(MULHU, rand_operand(), rand_operand());
    flush_i = 1'b1;
    issue(MULH, rand_operand(), rand_operand());
    flush_i = 1'b0;
    while (mult_ready_o !== 1'b1) step();
    flush_i = 1'b1;
    issue(REMU, rand_operand(), 64'd3);
    flush_i = 1'b0;
    issue_div(DIVW, rand_operand(), rand_operand());
    finish_test();

    // random mix of everything
    test_num = 6;
    for (int i = 0; i < N_MIX; i++) begin
      op = fu_op_e'($urandom_range(12));
      if (is_div_op(op)) issue_div(op, rand_operand(), rand_operand());
      else issue(op, rand_operand(), rand_operand());
      if ($urandom_range(3) == 0) step();
    end
    finish_test();

    $display("tests passed %0d, tests failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == 6) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog sized from the operation count
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles, results still outstanding", cycle_cnt);
      $display("STATUS: FAIL");
      $finish;
    end
  end

endmodule

// ==== mult_unit.f ====
hw/muldiv_cfg_pkg.sv
hw/muldiv_op_pkg.sv
hw/multiplier.sv
hw/serdiv.sv
hw/mult_unit.sv
dv/tb_clk_gen.sv
dv/tb_mult_checker.sv
dv/tb_mult_unit.sv

// ==== Bender.yml ====
package:
  name: mult_unit

sources:
  - files:
      - hw/muldiv_cfg_pkg.sv
      - hw/muldiv_op_pkg.sv
      - hw/multiplier.sv
      - hw/serdiv.sv
      - hw/mult_unit.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_mult_checker.sv
      - dv/tb_mult_unit.sv
